// ==== all.f ====
+incdir+source
+incdir+tests
source/forth_pkg.sv
source/stack_if.sv
source/program_mem.sv
source/forth_sequencer.sv
source/data_stack.sv
source/io_port.sv
source/forth_core.sv
tests/forth_core_tb.sv

// ==== source/data_stack.sv ====
//////////////////////////////////////////////////
// circular data stack
//////////////////////////////////////////////////
`timescale 1ns/100ps
`include "forth_consts.svh"

module data_stack (
  input  logic   clk,
  input  logic   reset,
  stack_if.stack stk
);
  import forth_pkg::*;

  localparam int    PW         = `FORTH_STACK_PW;
  // comparison results
  localparam cell_t cell_true  = '1;
  localparam cell_t cell_false = '0;

  cell_t         entry [`FORTH_STACK_DEPTH];
  // sp points at tos, wraps both ways
  logic [PW-1:0] sp;
  logic [PW-1:0] sp_up;
  logic [PW-1:0] sp_dn;
  logic [PW-1:0] sp_next;
  logic          wr_en;
  logic [PW-1:0] wr_addr;
  cell_t         wr_data;

  assign sp_up = sp + 1'b1;
  assign sp_dn = sp - 1'b1;

  // top two items straight from the array
  assign stk.tos      = entry[sp];
  assign stk.nos      = entry[sp_dn];
  assign stk.pop_zero = (stk.tos == '0);

  //////////////////////////////////////////////////
  // command decode
  //////////////////////////////////////////////////

  always_comb begin
    sp_next = sp;
    wr_en   = 1'b0;
    wr_addr = sp;
    wr_data = stk.tos;

    case (stk.cmd)
      st_push, st_dup, st_over: begin
        sp_next = sp_up;
        wr_en   = 1'b1;
        wr_addr = sp_up;
        if (stk.cmd == st_push) begin
          wr_data = stk.push_value;
        end else if (stk.cmd == st_over) begin
          wr_data = stk.nos;
        end
      end
      st_pop: sp_next = sp_dn;
      // two operands in, one result into the nos slot
      st_add, st_sub, st_and, st_or, st_equal: begin
        sp_next = sp_dn;
        wr_en   = 1'b1;
        wr_addr = sp_dn;
        case (stk.cmd)
          st_add:  wr_data = stk.nos + stk.tos;
          st_sub:  wr_data = stk.nos - stk.tos;
          st_and:  wr_data = stk.nos & stk.tos;
          st_or:   wr_data = stk.nos | stk.tos;
          default: wr_data = (stk.nos == stk.tos) ? cell_true : cell_false;
        endcase
      end
      // in place on tos
      st_zero_equal: begin
        wr_en   = 1'b1;
        wr_data = stk.pop_zero ? cell_true : cell_false;
      end
      st_replace: begin
        wr_en   = 1'b1;
        wr_data = stk.push_value;
      end
      default: ;
    endcase
  end

  //////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!reset) begin
      sp <= '0;
      for (int i = 0; i < `FORTH_STACK_DEPTH; i++) begin
        entry[i] <= '0;
      end
    end else begin
      sp <= sp_next;
      if (wr_en) begin
        entry[wr_addr] <= wr_data;
      end
    end
  end

endmodule

// ==== source/forth_consts.svh ====
//////////////////////////////////////////////////
// forth core constants
//////////////////////////////////////////////////
`ifndef FORTH_CONSTS_SVH
`define FORTH_CONSTS_SVH

// width of a stack item and a program cell
`define FORTH_CELL_WIDTH 32

// low bits of a cell read as opcode
`define FORTH_OP_WIDTH 8

// data stack entries, pointer wraps
`define FORTH_STACK_DEPTH 16
`define FORTH_STACK_PW $clog2(`FORTH_STACK_DEPTH)

// program cells and derived address width
`define FORTH_PROG_DEPTH 64
`define FORTH_PROG_AW $clog2(`FORTH_PROG_DEPTH)

`endif

// ==== source/forth_core.sv ====
//////////////////////////////////////////////////
// forth stack processor top
//////////////////////////////////////////////////
`timescale 1ns/100ps
`include "forth_consts.svh"

module forth_core (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      run,
  input  logic                      load_en,
  input  logic [`FORTH_PROG_AW-1:0] load_addr,
  input  forth_pkg::cell_t          load_data,
  input  logic                      button0,
  input  logic                      button1,
  output logic                      led_g,
  output logic                      led_b,
  output logic                      led_r,
  output logic                      emit_valid,
  output logic [7:0]                emit_data
);
  import forth_pkg::*;

  logic [`FORTH_PROG_AW-1:0] fetch_addr;
  cell_t                     fetch_cell;
  logic [1:0]                buttons;
  logic                      led_load;
  logic                      emit_load;

  // sequencer to stack
  stack_if stk_bus ();

  // loads only land while halted
  program_mem program_mem_inst (
    .clk       (clk),
    .load_en   (load_en && !run),
    .load_addr (load_addr),
    .load_data (load_data),
    .fetch_addr(fetch_addr),
    .fetch_cell(fetch_cell)
  );

  forth_sequencer forth_sequencer_inst (
    .clk       (clk),
    .reset     (reset),
    .run       (run),
    .fetch_addr(fetch_addr),
    .fetch_cell(fetch_cell),
    .buttons   (buttons),
    .stk       (stk_bus.sequencer),
    .led_load  (led_load),
    .emit_load (emit_load)
  );

  data_stack data_stack_inst (
    .clk  (clk),
    .reset(reset),
    .stk  (stk_bus.stack)
  );

  // tos taken from the stack side of the bus
  io_port io_port_inst (
    .clk       (clk),
    .reset     (reset),
    .button0   (button0),
    .button1   (button1),
    .led_load  (led_load),
    .emit_load (emit_load),
    .tos       (stk_bus.tos),
    .buttons   (buttons),
    .led_g     (led_g),
    .led_b     (led_b),
    .led_r     (led_r),
    .emit_valid(emit_valid),
    .emit_data (emit_data)
  );

endmodule

// ==== source/forth_pkg.sv ====
//////////////////////////////////////////////////
// forth core types
//////////////////////////////////////////////////
`include "forth_consts.svh"

package forth_pkg;

  // one stack item or program cell
  typedef logic [`FORTH_CELL_WIDTH-1:0] cell_t;

  // opcodes in the low byte of a cell
  // values fixed, programs are written as numbers
  typedef enum logic [`FORTH_OP_WIDTH-1:0] {
    op_nop        = 0,
    op_lit        = 1,
    op_plus       = 2,
    op_minus      = 3,
    op_dup        = 4,
    op_over       = 5,
    op_drop       = 6,
    op_equal      = 7,
    op_zero_equal = 8,
    op_and        = 9,
    op_or         = 10,
    op_branch     = 11,
    op_zero_branch = 12,
    op_io_led     = 13,
    op_io_button  = 14,
    op_emit       = 15
  } forth_op_e;

  // commands from sequencer to data stack
  typedef enum logic [3:0] {
    st_none, st_push, st_pop, st_dup, st_over, st_add, st_sub,
    st_and, st_or, st_equal, st_zero_equal, st_replace
  } stack_op_e;

  // sequencer states
  typedef enum logic [1:0] {
    s_halt,
    s_exec,
    s_operand
  } seq_state_e;

endpackage

// ==== source/forth_sequencer.sv ====
//////////////////////////////////////////////////
// forth sequencer
//////////////////////////////////////////////////
`timescale 1ns/100ps
`include "forth_consts.svh"

module forth_sequencer (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      run,
  output logic [`FORTH_PROG_AW-1:0] fetch_addr,
  input  forth_pkg::cell_t          fetch_cell,
  input  logic [1:0]                buttons,
  stack_if.sequencer                stk,
  output logic                      led_load,
  output logic                      emit_load
);
  import forth_pkg::*;

  localparam int AW = `FORTH_PROG_AW;

  seq_state_e    state;
  seq_state_e    state_next;
  logic [AW-1:0] pc;
  logic [AW-1:0] pc_next;
  logic [AW-1:0] pc_step;
  // two-cell opcode waiting for its operand
  forth_op_e     pend_op;
  forth_op_e     pend_next;
  // tos was zero when zero_branch popped it
  logic          zero_flag;
  logic          zero_next;
  forth_op_e     op;

  assign fetch_addr = pc;
  assign pc_step    = pc + 1'b1;
  assign op         = forth_op_e'(fetch_cell[`FORTH_OP_WIDTH-1:0]);

  //////////////////////////////////////////////////
  // decode and next state
  //////////////////////////////////////////////////

  always_comb begin
    state_next     = state;
    pc_next        = pc;
    pend_next      = pend_op;
    zero_next      = zero_flag;
    stk.cmd        = st_none;
    stk.push_value = '0;
    led_load       = 1'b0;
    emit_load      = 1'b0;

    if (!run) begin
      // halted, pc parked at 0 for loading
      state_next = s_halt;
      pc_next    = '0;
    end else begin
      case (state)
        s_halt: begin
          state_next = s_exec;
        end

        s_exec: begin
          pc_next = pc_step;
          case (op)
            op_plus:       stk.cmd = st_add;
            op_minus:      stk.cmd = st_sub;
            op_dup:        stk.cmd = st_dup;
            op_over:       stk.cmd = st_over;
            op_drop:       stk.cmd = st_pop;
            op_equal:      stk.cmd = st_equal;
            op_zero_equal: stk.cmd = st_zero_equal;
            op_and:        stk.cmd = st_and;
            op_or:         stk.cmd = st_or;
            op_lit, op_branch: begin
              pend_next  = op;
              state_next = s_operand;
            end
            op_zero_branch: begin
              // pop now, remember the test for next cycle
              stk.cmd    = st_pop;
              zero_next  = stk.pop_zero;
              pend_next  = op;
              state_next = s_operand;
            end
            // led bits latched from tos, no pop
            op_io_led:     led_load = 1'b1;
            op_io_button: begin
              stk.cmd        = st_replace;
              stk.push_value = {{(`FORTH_CELL_WIDTH-2){1'b0}}, buttons};
            end
            op_emit: begin
              stk.cmd   = st_pop;
              emit_load = 1'b1;
            end
            // nop and unknown codes
            default: ;
          endcase
        end

        s_operand: begin
          // fetch_cell now holds the operand
          state_next = s_exec;
          case (pend_op)
            op_lit: begin
              stk.cmd        = st_push;
              stk.push_value = fetch_cell;
              pc_next        = pc_step;
            end
            op_branch:      pc_next = fetch_cell[AW-1:0];
            op_zero_branch: pc_next = zero_flag ? fetch_cell[AW-1:0] : pc_step;
            default:        pc_next = pc_step;
          endcase
        end

        default: state_next = s_halt;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!reset) begin
      state     <= s_halt;
      pc        <= '0;
      pend_op   <= op_nop;
      zero_flag <= 1'b0;
    end else begin
      state     <= state_next;
      pc        <= pc_next;
      pend_op   <= pend_next;
      zero_flag <= zero_next;
    end
  end

endmodule

// ==== source/io_port.sv ====
//////////////////////////////////////////////////
// board i/o
//////////////////////////////////////////////////
`timescale 1ns/100ps

module io_port (
  input  logic             clk,
  input  logic             reset,
  input  logic             button0,
  input  logic             button1,
  input  logic             led_load,
  input  logic             emit_load,
  input  forth_pkg::cell_t tos,
  output logic [1:0]       buttons,
  output logic             led_g,
  output logic             led_b,
  output logic             led_r,
  output logic             emit_valid,
  output logic [7:0]       emit_data
);

  // two-flop synchronizer, bit 1 is button1
  logic [1:0] btn_meta;
  logic [1:0] btn_sync;

  always_ff @(posedge clk) begin
    if (!reset) begin
      btn_meta <= '0;
      btn_sync <= '0;
    end else begin
      btn_meta <= {button1, button0};
      btn_sync <= btn_meta;
    end
  end

  assign buttons = btn_sync;

  // leds are active low, 1 is off
  always_ff @(posedge clk) begin
    if (!reset) begin
      led_g <= 1'b1;
      led_b <= 1'b1;
    end else if (led_load) begin
      led_g <= ~tos[0];
      led_b <= ~tos[1];
    end
  end

  // red not driven by any opcode
  assign led_r = 1'b1;

  // emit strobe, one cycle, no hold
  always_ff @(posedge clk) begin
    if (!reset) begin
      emit_valid <= 1'b0;
      emit_data  <= '0;
    end else begin
      emit_valid <= emit_load;
      if (emit_load) begin
        emit_data <= tos[7:0];
      end
    end
  end

endmodule

// ==== source/program_mem.sv ====
//////////////////////////////////////////////////
// program memory
//////////////////////////////////////////////////
`timescale 1ns/100ps
`include "forth_consts.svh"

module program_mem (
  input  logic                     clk,
  input  logic                     load_en,
  input  logic [`FORTH_PROG_AW-1:0] load_addr,
  input  forth_pkg::cell_t         load_data,
  input  logic [`FORTH_PROG_AW-1:0] fetch_addr,
  output forth_pkg::cell_t         fetch_cell
);
  import forth_pkg::*;

  // cell array, contents come from the load port only
  cell_t cells [`FORTH_PROG_DEPTH];

  //////////////////////////////////////////////////
  // load port
  //////////////////////////////////////////////////

  // one cell per clock while loading
  always_ff @(posedge clk) begin
    if (load_en) begin
      cells[load_addr] <= load_data;
    end
  end

  //////////////////////////////////////////////////
  // fetch port
  //////////////////////////////////////////////////

  // combinational read, sequencer sees the cell
  // at pc in the same cycle
  assign fetch_cell = cells[fetch_addr];

endmodule

// ==== source/stack_if.sv ====
//////////////////////////////////////////////////
// data stack bus
//////////////////////////////////////////////////
`timescale 1ns/100ps

interface stack_if;
  import forth_pkg::*;

  // one-cycle command strobe, st_none when idle
  stack_op_e cmd;
  // value for push and replace
  cell_t     push_value;

  // top two items, always valid
  cell_t     tos;
  cell_t     nos;
  logic      pop_zero;

  // control side
  modport sequencer (
    output cmd, push_value,
    input  tos, pop_zero
  );

  // storage side
  modport stack (
    input  cmd, push_value,
    output tos, nos, pop_zero
  );

endinterface

// ==== tests/forth_core_tasks.svh ====
//////////////////////////////////////////////////
// forth core testbench tasks
//////////////////////////////////////////////////
`ifndef FORTH_CORE_TASKS_SVH
`define FORTH_CORE_TASKS_SVH

// compare one value against the expected one
task automatic check_value(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
  if (expected !== actual) begin
    $display("Error: %s %s expected %0h actual %0h", test_name, what, expected, actual);
    test_failed = 1'b1;
  end
endtask

// fresh record with new random operands
task automatic start_record();
  prog_addr.delete();
  prog_val.delete();
  exp_emit.delete();
  run_budget  = 100;
  led_check   = 1'b0;
  btn_level   = 2'b00;
  test_failed = 1'b0;
  mode        = 0;
  at_addr     = 0;
  rnd[0]      = $random(seed);
  rnd[1]      = $random(seed);
endtask

// one cell per falling edge while run is low
task automatic load_program();
  for (int i = 0; i < prog_val.size(); i++) begin
    @(negedge clk);
    load_en   = 1'b1;
    load_addr = prog_addr[i][`FORTH_PROG_AW-1:0];
    load_data = prog_val[i];
  end
  @(negedge clk);
  load_en = 1'b0;
endtask

// gather emit strobes over the cycle budget
// stops early once an emit beyond the expected ones shows up
task automatic collect_emits(output logic timed_out);
  int cycles;
  cycles = 0;
  got.delete();
  while (got.size() <= exp_emit.size() && cycles < run_budget) begin
    @(negedge clk);
    cycles++;
    if (emit_valid) begin
      got.push_back(emit_data);
    end
  end
  timed_out = (got.size() < exp_emit.size());
endtask

// one line per finished test
task automatic report_test();
  if (test_failed) begin
    fail_count++;
    $display("test %s: fail", test_name);
  end else begin
    pass_count++;
    $display("test %s: pass", test_name);
  end
endtask

`endif

// ==== tests/forth_core_tb.sv ====
//////////////////////////////////////////////////
// forth core testbench
//////////////////////////////////////////////////
`timescale 1ns/100ps
`include "forth_consts.svh"

module forth_core_tb;

  logic                         clk;
  logic                         reset;
  logic                         run;
  logic                         load_en;
  logic [`FORTH_PROG_AW-1:0]    load_addr;
  logic [`FORTH_CELL_WIDTH-1:0] load_data;
  logic                         button0;
  logic                         button1;
  logic                         led_g;
  logic                         led_b;
  logic                         led_r;
  logic                         emit_valid;
  logic [7:0]                   emit_data;

  // current test record from the stimulus file
  string       test_name;
  int          prog_addr [$];
  logic [31:0] prog_val [$];
  logic [7:0]  exp_emit [$];
  logic [7:0]  got [$];
  int          run_budget;
  logic        led_check;
  // expected {led_g, led_b}
  logic [1:0]  led_exp;
  // {button1, button0}
  logic [1:0]  btn_level;
  logic [31:0] rnd [2];
  int          mode;
  int          at_addr;
  logic        test_failed;
  integer      seed;
  int          pass_count;
  int          fail_count;

  `include "forth_core_tasks.svh"

  forth_core forth_core_inst (
    .clk       (clk),
    .reset     (reset),
    .run       (run),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .button0   (button0),
    .button1   (button1),
    .led_g     (led_g),
    .led_b     (led_b),
    .led_r     (led_r),
    .emit_valid(emit_valid),
    .emit_data (emit_data)
  );

  // 20 ns clock
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // one test loads, runs, collects and compares
  //////////////////////////////////////////////////

  task automatic run_test();
    logic timed_out;
    @(negedge clk);
    run     = 1'b0;
    button1 = btn_level[1];
    button0 = btn_level[0];
    load_program();
    @(negedge clk);
    run = 1'b1;
    collect_emits(timed_out);
    @(negedge clk);
    run = 1'b0;
    if (timed_out) begin
      $display("test %s: only %0d of %0d emits arrived within %0d cycles",
               test_name, got.size(), exp_emit.size(), run_budget);
      test_failed = 1'b1;
    end
    if (got.size() > exp_emit.size()) begin
      $display("test %s: more than the %0d expected emits arrived, the program did not halt",
               test_name, exp_emit.size());
      test_failed = 1'b1;
    end
    for (int i = 0; i < got.size() && i < exp_emit.size(); i++) begin
      check_value($sformatf("emit %0d", i), exp_emit[i], got[i]);
    end
    if (led_check) begin
      check_value("led_g", led_exp[1], led_g);
      check_value("led_b", led_exp[0], led_b);
    end
    // red led never driven
    check_value("led_r", 1, led_r);
    report_test();
  endtask

  //////////////////////////////////////////////////
  // stimulus parser and main flow
  //////////////////////////////////////////////////

  initial begin
    int          fd;
    int          code;
    int          ch;
    int          b_hi;
    int          b_lo;
    string       tok;
    logic [31:0] val;

    seed       = 4;
    pass_count = 0;
    fail_count = 0;
    reset      = 1'b0;
    run        = 1'b0;
    load_en    = 1'b0;
    load_addr  = '0;
    load_data  = '0;
    button0    = 1'b0;
    button1    = 1'b0;
    start_record();

    // reset low for 8 cycles
    repeat (8) @(negedge clk);
    reset = 1'b1;

    fd = $fopen("tests/forth_stimulus.txt", "r");
    if (fd == 0) begin
      $display("the stimulus file tests/forth_stimulus.txt could not be opened");
      fail_count++;
    end else begin
      while ($fscanf(fd, "%s", tok) == 1) begin
        if (tok.getc(0) == "#") begin
          // skip comment to end of line
          ch = $fgetc(fd);
          while (ch != 10 && ch != -1) begin
            ch = $fgetc(fd);
          end
        end else if (tok == "test") begin
          start_record();
          code = $fscanf(fd, "%s", test_name);
        end else if (tok == "buttons") begin
          code      = $fscanf(fd, "%d %d", b_hi, b_lo);
          btn_level = {b_hi[0], b_lo[0]};
        end else if (tok == "at") begin
          code = $fscanf(fd, "%h", at_addr);
          mode = 0;
        end else if (tok == "run") begin
          code = $fscanf(fd, "%d", run_budget);
        end else if (tok == "expect") begin
          mode = 1;
        end else if (tok == "led") begin
          code      = $fscanf(fd, "%d %d", b_hi, b_lo);
          led_exp   = {b_hi[0], b_lo[0]};
          led_check = 1'b1;
        end else if (tok == "end") begin
          run_test();
        end else if (mode == 0) begin
          // program cell or random operand
          if (tok == "r0") begin
            val = rnd[0];
          end else if (tok == "r1") begin
            val = rnd[1];
          end else begin
            code = $sscanf(tok, "%h", val);
          end
          prog_addr.push_back(at_addr);
          prog_val.push_back(val);
          at_addr++;
        end else begin
          // low bytes of a+b and a-b
          if (tok == "sum") begin
            exp_emit.push_back(8'(rnd[0] + rnd[1]));
          end else if (tok == "diff") begin
            exp_emit.push_back(8'(rnd[0] - rnd[1]));
          end else begin
            code = $sscanf(tok, "%h", val);
            exp_emit.push_back(val[7:0]);
          end
        end
      end
      $fclose(fd);
    end

    $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
    if (fail_count == 0 && pass_count > 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== tests/forth_stimulus.txt ====
# test <name> | buttons <button1> <button0> | at <hex addr> then hex cells, r0 r1 random
# run <max cycles> | expect <hex bytes, sum, diff> | led <led_g> <led_b> | end
test arith
at 00 01 r0 01 r1 02 0f 01 r0 01 r1 03 0f 0b 0c
run 60
expect sum diff
end
test logic
at 00 01 ffffffff 01 0 09 0f 01 ffffffff 01 0 0a 0f
at 0c 01 5 01 5 07 0f 01 0 08 0f 01 7 08 0f 0b 1a
run 100
expect 00 ff ff ff 00
end
test shuffle
at 00 01 11 01 22 05 0f 0f 0f 01 33 04 0f 0f 01 44 01 55 06 0f 0b 13
run 100
expect 11 22 11 33 33 44
end
test countdown
at 00 01 04 04 0f 01 01 03 04 0c 0c 0b 02 0b 0c
run 150
expect 04 03 02 01
end
test led_one
at 00 01 1 0d 0f 0b 04
run 40
expect 01
led 0 1
end
test led_two
at 00 01 2 0d 0f 0b 04
run 40
expect 02
led 1 0
end
test button_hi
buttons 1 0
at 00 01 0 0e 0f 0b 04
run 40
expect 02
end
test button_lo
buttons 0 1
at 00 01 0 0e 0f 0b 04
run 40
expect 01
end
